//--- bench/fml_mem_model.sv
`timescale 1ns/1ps

module fml_mem_model import fmlbrg_pkg::*; (
	input  logic                sys_clk,
	input  fml_req_t            fml_i,
	input  logic [OFFSET_W-1:0] start_i,     // offset of the word that missed
	output logic                fml_ack_o,
	output logic [15:0]         fml_di_o
);

logic [15:0] store [int];     // sparse, keyed by word address
int          seed;
int          lat;
int          base;
int          start;
logic        we_r;

// unwritten words follow a fixed pattern of the whole address
function automatic logic [15:0] peek(input int adr);
	if (store.exists(adr))
		return store[adr];
	return 16'(adr * 32'h9E37 + 32'h1234);
endfunction

initial begin
	seed = 65;
	fml_ack_o = 1'b0;
	fml_di_o = '0;
	forever begin
		@(posedge sys_clk);
		if (fml_i.stb) begin
			lat = 1 + ($unsigned($random(seed)) % 4);
			repeat (lat - 1) @(posedge sys_clk);
			fml_ack_o <= 1'b1;
			@(posedge sys_clk);              // the controller takes the ack here
			fml_ack_o <= 1'b0;
			base = int'(fml_i.adr >> 1);
			start = start_i;
			we_r = fml_i.we;
			// beats wrap inside the line, starting at the missed word
			for (int k = 0; k < LINE_WORDS; k++) begin
				if (k > 0)
					@(posedge sys_clk);
				if (we_r)
					store[base + (start + k) % LINE_WORDS] = fml_i.dat;
				else
					fml_di_o <= peek(base + (start + k) % LINE_WORDS);
			end
		end
	end
end

endmodule

//--- bench/tb_fmlbrg.sv
`timescale 1ns/1ps

module tb_fmlbrg import fmlbrg_pkg::*;;

localparam int NUM_OPS = 120;
localparam int GAP = 8;           // idle cycles after each bus cycle, covers the refill tail

logic        sys_clk;
logic        sys_rst;
bus_req_t    bus_req;
logic        wb_cyc_i;
logic        wb_stb_i;
logic [15:0] wb_dat_o;
logic        wb_ack_o;
fml_req_t    fml;
logic        fml_ack;
logic [15:0] fml_di;
logic        dcb_stb_i;
word_adr_u   dcb_adr_i;
logic [15:0] dcb_dat_o;
logic        dcb_hit_o;

int          seed;
int          mism_cnt;
int          fail_cnt;
logic [15:0] shadow [int];        // every word the bus has written
logic [15:0] wbuf [0:7];          // write data of the next bus cycle
int          rd_q [$];            // word addresses still waiting for a read ack
bit          rand_phase;
bit          dcb_en;
bit          dcb_drv;
logic        dcb_smp_stb;
word_adr_u   dcb_smp_adr;
int          lat;
bit          consec;
word_adr_u   a;
int          r;

fmlbrg_top uut (
	.sys_clk, .sys_rst, .bus_req_i(bus_req), .wb_cyc_i, .wb_stb_i, .wb_dat_o, .wb_ack_o,
	.fml_o(fml), .fml_ack_i(fml_ack), .fml_di_i(fml_di),
	.dcb_stb_i, .dcb_adr_i, .dcb_dat_o, .dcb_hit_o
);

fml_mem_model mem (
	.sys_clk, .fml_i(fml), .start_i(bus_req.adr.f.offset), .fml_ack_o(fml_ack),
	.fml_di_o(fml_di)
);

initial begin
	sys_clk = 1'b0;
	forever #20 sys_clk = ~sys_clk;
end

// ******************************
// reference model
// ******************************
function automatic logic [15:0] exp_word(input int adr);
	if (shadow.exists(adr))
		return shadow[adr];
	return 16'(adr * 32'h9E37 + 32'h1234);    // memory power-up pattern
endfunction

function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] nw,
		input logic [1:0] sel);
	logic [15:0] res;
	res = old;
	if (sel[0])
		res[7:0] = nw[7:0];
	if (sel[1])
		res[15:8] = nw[15:8];
	return res;
endfunction

function automatic word_adr_u mk(input int t, input int x, input int o);
	word_adr_u res;
	res.f.tag = TAG_W'(t);
	res.f.index = INDEX_W'(x);
	res.f.offset = OFFSET_W'(o);
	return res;
endfunction

function automatic word_adr_u word_at(input word_adr_u a0, input int k);
	word_adr_u res;
	res = a0;
	res.f.offset = OFFSET_W'(a0.f.offset + k);    // wraps inside the line
	return res;
endfunction

function automatic word_adr_u rand_adr();
	word_adr_u res;
	res.f.tag = TAG_W'($unsigned($random(seed)) % 4);    // few tags, so lines get reused
	res.f.index = INDEX_W'($random(seed));
	res.f.offset = OFFSET_W'($random(seed));
	return res;
endfunction

task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp) begin
		$display("Mismatch %s: got %h, expected %h", name, got, exp);
		mism_cnt++;
	end
endtask

// ******************************
// bus master
// ******************************
task automatic drive_word(input word_adr_u a0, input int i, input int len, input logic we,
		input logic tga, input logic [1:0] sel);
	bus_req.adr = word_at(a0, i);
	bus_req.dat = wbuf[i];
	bus_req.sel = sel;
	bus_req.we = we;
	bus_req.tga = tga;
	bus_req.cti = (i < len - 1) ? CTI_INCR : 3'b000;
endtask

task automatic bus_op(input word_adr_u a0, input int len, input logic we, input logic tga,
		input logic [1:0] sel, output int first_lat, output bit all_consec);
	word_adr_u wa;
	int        i;
	int        waited;
	bit        hold;
	bit        ack_s;
	bit        done;
	first_lat = 0;
	all_consec = 1;
	i = 0;
	waited = 0;
	hold = 0;
	done = 0;
	dcb_en = rand_phase && !we && !tga;
	for (int k = 0; k < len && !we && !tga; k++) begin
		wa = word_at(a0, k);
		rd_q.push_back(int'(wa.flat));
	end
	drive_word(a0, 0, len, we, tga, sel);
	wb_cyc_i = 1'b1;
	wb_stb_i = 1'b1;
	while (!done) begin
		@(negedge sys_clk);
		ack_s = wb_ack_o;
		if (hold) begin                    // request held through the ack cycle
			hold = 0;
			if (i == len) begin
				wb_cyc_i = 1'b0;
				wb_stb_i = 1'b0;
				done = 1;
			end else begin
				drive_word(a0, i, len, we, tga, sel);
				if (ack_s) begin
					i++;
					hold = 1;
				end else
					all_consec = 0;
			end
		end else if (ack_s) begin
			if (i == 0)
				first_lat = waited + 2;        // IDLE cycle plus TEST_HIT cycle
			else
				all_consec = 0;
			i++;
			hold = 1;
		end else begin
			waited++;
			if (waited > 300) begin
				$display("no ack for bus cycle at word address %h", a0.flat);
				fail_cnt++;
				wb_cyc_i = 1'b0;
				wb_stb_i = 1'b0;
				rd_q.delete();
				done = 1;
			end
		end
	end
	for (int k = 0; k < len && we; k++) begin
		wa = word_at(a0, k);
		shadow[int'(wa.flat)] = merge(exp_word(int'(wa.flat)), wbuf[k], sel);
	end
	repeat (GAP) @(negedge sys_clk);
endtask

task automatic check_line(input int t, input int x);
	word_adr_u wa;
	for (int o = 0; o < LINE_WORDS; o++) begin
		wa = mk(t, x, o);
		check_val("memory word", mem.peek(int'(wa.flat)), exp_word(int'(wa.flat)));
	end
endtask

task automatic dcb_probe(input word_adr_u pa, input logic expect_hit);
	dcb_en = 0;
	repeat (3) @(negedge sys_clk);          // let random lookups drain
	dcb_stb_i = 1'b1;
	dcb_adr_i = pa;
	@(negedge sys_clk);
	dcb_stb_i = 1'b0;
	if (dcb_hit_o !== expect_hit) begin
		if (expect_hit)
			$display("direct port missed line %h that the bus just read", pa.flat);
		else
			$display("direct port hit invalidated line %h", pa.flat);
		fail_cnt++;
	end
endtask

// random direct port traffic
initial begin
	forever begin
		@(negedge sys_clk);
		if (dcb_en) begin
			dcb_stb_i = $random(seed) & 1;
			dcb_adr_i = rand_adr();
			dcb_drv = 1;
		end else if (dcb_drv) begin
			dcb_stb_i = 1'b0;
			dcb_drv = 0;
		end
	end
end

// ******************************
// compare
// ******************************
always @(posedge sys_clk) begin
	dcb_smp_stb <= dcb_stb_i;
	dcb_smp_adr <= dcb_adr_i;
end

always @(negedge sys_clk) begin
	if (dcb_hit_o) begin
		if (!dcb_smp_stb) begin
			$display("direct port hit without a strobe");
			fail_cnt++;
		end else
			check_val("dcb_dat_o", dcb_dat_o, exp_word(int'(dcb_smp_adr.flat)));
	end
	if (wb_ack_o && rd_q.size() > 0)
		check_val("wb_dat_o", wb_dat_o, exp_word(rd_q.pop_front()));
end

initial begin
	#(longint'(NUM_OPS * 40 + 500) * 40);
	$display("watchdog expired before the bus traffic finished");
	$display("Something failed");
	$finish;
end

initial begin
	seed = 65;
	mism_cnt = 0;
	fail_cnt = 0;
	rand_phase = 0;
	dcb_en = 0;
	dcb_drv = 0;
	sys_rst = 1'b1;
	bus_req = '0;
	wb_cyc_i = 1'b0;
	wb_stb_i = 1'b0;
	dcb_stb_i = 1'b0;
	dcb_adr_i = '0;
	for (int k = 0; k < 8; k++)
		wbuf[k] = 16'h0;
	repeat (2) @(negedge sys_clk);
	sys_rst = 1'b0;
	repeat (2) @(negedge sys_clk);

	// misses, then hits on the same lines
	foreach (wbuf[x]) begin
		if (x < 3) begin
			bus_op(mk(1, 2 + 3 * x, 3), 1, 1'b0, 1'b0, 2'b11, lat, consec);
			bus_op(mk(1, 2 + 3 * x, 3), 1, 1'b0, 1'b0, 2'b11, lat, consec);
			check_val("hit ack latency", 16'(lat), 16'd2);
		end
	end

	// byte writes on hit lines and miss lines
	wbuf[0] = 16'hA5C3;
	bus_op(mk(1, 2, 3), 1, 1'b1, 1'b0, 2'b01, lat, consec);
	wbuf[0] = 16'h5A3C;
	bus_op(mk(1, 2, 4), 1, 1'b1, 1'b0, 2'b10, lat, consec);
	bus_op(mk(1, 5, 1), 1, 1'b1, 1'b0, 2'b11, lat, consec);
	bus_op(mk(2, 10, 6), 1, 1'b1, 1'b0, 2'b01, lat, consec);
	bus_op(mk(2, 11, 0), 1, 1'b1, 1'b0, 2'b10, lat, consec);
	bus_op(mk(1, 2, 3), 2, 1'b0, 1'b0, 2'b11, lat, consec);
	bus_op(mk(1, 5, 1), 1, 1'b0, 1'b0, 2'b11, lat, consec);
	bus_op(mk(2, 10, 6), 1, 1'b0, 1'b0, 2'b11, lat, consec);
	bus_op(mk(2, 11, 0), 1, 1'b0, 1'b0, 2'b11, lat, consec);

	// conflicting tags push the dirty lines out
	bus_op(mk(5, 2, 6), 1, 1'b0, 1'b0, 2'b11, lat, consec);
	check_line(1, 2);
	bus_op(mk(5, 10, 0), 1, 1'b0, 1'b0, 2'b11, lat, consec);
	check_line(2, 10);
	bus_op(mk(1, 2, 3), 2, 1'b0, 1'b0, 2'b11, lat, consec);

	// ******************************
	// incrementing bursts
	// ******************************
	bus_op(mk(3, 7, 0), 1, 1'b0, 1'b0, 2'b11, lat, consec);
	for (int len = 2; len <= 8; len++) begin
		bus_op(mk(3, 7, len * 3), len, 1'b0, 1'b0, 2'b11, lat, consec);
		if (!consec || lat != 2) begin
			$display("read burst of %0d words did not ack on consecutive cycles", len);
			fail_cnt++;
		end
	end
	for (int k = 0; k < 4; k++)
		wbuf[k] = 16'hB000 + 16'(k * 16'h0111);
	bus_op(mk(3, 7, 6), 4, 1'b1, 1'b0, 2'b11, lat, consec);
	if (!consec) begin
		$display("write burst did not ack on consecutive cycles");
		fail_cnt++;
	end
	bus_op(mk(3, 7, 0), 8, 1'b0, 1'b0, 2'b11, lat, consec);

	// invalidate of a dirty line writes it back first
	wbuf[0] = 16'h1357;
	bus_op(mk(4, 12, 5), 1, 1'b1, 1'b0, 2'b11, lat, consec);
	bus_op(mk(4, 12, 2), 1, 1'b0, 1'b1, 2'b11, lat, consec);
	check_line(4, 12);
	dcb_probe(mk(4, 12, 5), 1'b0);
	bus_op(mk(4, 12, 5), 1, 1'b0, 1'b0, 2'b11, lat, consec);

	// random direct lookups alongside bus traffic
	rand_phase = 1;
	for (int n = 0; n < 40; n++) begin
		r = $unsigned($random(seed)) % 8;
		a = rand_adr();
		if (r == 0) begin
			wbuf[0] = 16'($random(seed));
			bus_op(a, 1, 1'b1, 1'b0, 2'($unsigned($random(seed)) % 3 + 1), lat, consec);
		end else begin
			bus_op(a, (r == 1) ? 2 + $unsigned($random(seed)) % 7 : 1, 1'b0, 1'b0, 2'b11,
				lat, consec);
			dcb_probe(a, 1'b1);
		end
	end

	$display("checks done: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
	if (mism_cnt == 0 && fail_cnt == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

//--- common/fmlbrg_pkg.sv
package fmlbrg_pkg;

	// ******************************
	// address geometry
	// ******************************
	localparam int FML_DEPTH   = 23;                    // byte address width on the memory port
	localparam int CACHE_DEPTH = 9;                     // 512 byte cache
	localparam int TAG_W       = FML_DEPTH - CACHE_DEPTH;
	localparam int INDEX_W     = CACHE_DEPTH - 4;       // 16 byte lines
	localparam int OFFSET_W    = 3;
	localparam int LINE_WORDS  = 1 << OFFSET_W;         // beats per memory burst

	localparam logic [2:0] CTI_INCR = 3'b010;           // burst continues after this word

	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [INDEX_W-1:0]  index;
		logic [OFFSET_W-1:0] offset;
	} adr_fields_t;

	// word address, bit 0 of the byte address dropped
	typedef union packed {
		logic [FML_DEPTH-2:0] flat;
		adr_fields_t          f;
	} word_adr_u;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		word_adr_u   adr;
		logic [2:0]  cti;
		logic [15:0] dat;
		logic [1:0]  sel;
		logic        we;
		logic        tga;      // invalidate request
	} bus_req_t;

	typedef struct packed {
		logic [FML_DEPTH-1:0] adr;
		logic                 stb;
		logic                 we;
		logic [15:0]          dat;
	} fml_req_t;

	typedef enum logic [3:0] {
		IDLE, TEST_HIT, BUS_BURST, EVICT, EVICT_STREAM, REFILL_TAG,
		REFILL_WAIT, REFILL_REQ, REFILL_STREAM, TEST_INVALIDATE, INVALIDATE
	} ctrl_state_e;

endpackage

//--- fmlbrg/fmlbrg_ctrl.sv
`timescale 1ns/1ps

module fmlbrg_ctrl import fmlbrg_pkg::*; (
	input  logic                        sys_clk,
	input  logic                        sys_rst,

	input  bus_req_t                    bus_req_i,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	output logic                        wb_ack_o,
	output logic [15:0]                 wb_dat_o,

	output fml_req_t                    fml_o,
	input  logic                        fml_ack_i,
	input  logic [15:0]                 fml_di_i,

	output logic [INDEX_W-1:0]          tag_idx_o,
	output logic                        tag_we_o,
	output tag_entry_t                  tag_wr_o,
	input  tag_entry_t                  tag_rd_i,

	output logic [INDEX_W+OFFSET_W-1:0] data_adr_o,
	output logic [1:0]                  data_we_o,
	output logic [15:0]                 data_wr_o,
	input  logic [15:0]                 data_rd_i,

	input  logic                        dcb_conflict_i,
	output logic                        refill_busy_o,
	output logic [INDEX_W-1:0]          line_idx_o
);

ctrl_state_e          state;
ctrl_state_e          next_state;
word_adr_u            adr_r;          // request address captured in IDLE
word_adr_u            line_adr;       // line base sent to memory
logic [FML_DEPTH-1:0] fml_adr_r;
logic [OFFSET_W-1:0]  bcount;
logic [OFFSET_W-1:0]  bcount_next;
logic [OFFSET_W-1:0]  beat;
logic                 bc_load;
logic                 bc_inc;
logic                 wr_bus;         // bus bytes go to the data RAM
logic                 wr_fml;         // refill word goes to the data RAM
logic                 hit;
logic [INDEX_W-1:0]   cur_idx;

assign hit = tag_rd_i.valid && (tag_rd_i.tag == adr_r.f.tag);
assign beat = bcount - adr_r.f.offset;    // position inside a line transfer
assign cur_idx = (state == IDLE) ? bus_req_i.adr.f.index : adr_r.f.index;

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		state <= IDLE;
		bcount <= '0;
	end else begin
		state <= next_state;
		bcount <= bcount_next;
	end
end

always_ff @(posedge sys_clk) begin
	if (state == IDLE)
		adr_r <= bus_req_i.adr;
	fml_adr_r <= {line_adr.flat, 1'b0};
end

// ******************************
// burst counter
// ******************************
always_comb begin
	if (bc_load)
		bcount_next = bus_req_i.adr.f.offset;
	else if (bc_inc)
		bcount_next = bcount + OFFSET_W'(1);    // wraps inside the line
	else
		bcount_next = bcount;
end

// tag follows the tag RAM and so names the victim during eviction
always_comb begin
	line_adr.f.tag = tag_rd_i.tag;
	line_adr.f.index = adr_r.f.index;
	line_adr.f.offset = '0;
end

// refill writes land on the current count while other states look one ahead
assign data_adr_o = {cur_idx, (state == REFILL_STREAM) ? bcount : bcount_next};
assign tag_idx_o = cur_idx;
assign line_idx_o = adr_r.f.index;
assign refill_busy_o = state inside {REFILL_WAIT, REFILL_REQ, REFILL_STREAM};
assign wb_dat_o = data_rd_i;

assign fml_o.adr = fml_adr_r;
assign fml_o.stb = (state == EVICT) || (state == REFILL_REQ);
assign fml_o.we = (state == EVICT);
assign fml_o.dat = data_rd_i;

// ******************************
// write merge
// ******************************
always_comb begin
	if (wr_fml)
		data_we_o = 2'b11;
	else if (wr_bus)
		data_we_o = bus_req_i.sel;
	else
		data_we_o = 2'b00;
	data_wr_o = fml_di_i;
	if (wr_bus) begin
		if (bus_req_i.sel[0])
			data_wr_o[7:0] = bus_req_i.dat[7:0];
		if (bus_req_i.sel[1])
			data_wr_o[15:8] = bus_req_i.dat[15:8];
	end
end

// ******************************
// FSM
// ******************************
always_comb begin
	next_state = state;
	bc_load = 1'b0;
	bc_inc = 1'b0;
	wr_bus = 1'b0;
	wr_fml = 1'b0;
	wb_ack_o = 1'b0;
	tag_we_o = 1'b0;
	tag_wr_o = '{valid: 1'b0, dirty: 1'b0, tag: adr_r.f.tag};

	case (state)
		IDLE: begin
			bc_load = 1'b1;
			if (wb_cyc_i && wb_stb_i)
				next_state = bus_req_i.tga ? TEST_INVALIDATE : TEST_HIT;
		end
		TEST_HIT: begin
			if (hit) begin
				wb_ack_o = 1'b1;
				if (bus_req_i.we) begin
					wr_bus = 1'b1;
					tag_we_o = 1'b1;
					tag_wr_o.valid = 1'b1;
					tag_wr_o.dirty = 1'b1;
				end else
					bc_inc = 1'b1;          // fetch the next word of a read burst
				next_state = (bus_req_i.cti == CTI_INCR) ? BUS_BURST : IDLE;
			end else if (tag_rd_i.valid && tag_rd_i.dirty)
				next_state = EVICT;
			else
				next_state = REFILL_TAG;
		end
		BUS_BURST: begin
			wb_ack_o = 1'b1;
			bc_inc = 1'b1;
			wr_bus = bus_req_i.we;
			if (bus_req_i.cti != CTI_INCR)
				next_state = IDLE;
		end
		EVICT: begin                         // counter sits on the missed word
			if (fml_ack_i) begin
				bc_inc = 1'b1;
				next_state = EVICT_STREAM;
			end
		end
		EVICT_STREAM: begin
			bc_inc = 1'b1;
			if (beat == OFFSET_W'(LINE_WORDS - 1))
				next_state = bus_req_i.tga ? INVALIDATE : REFILL_TAG;
		end
		REFILL_TAG: begin
			if (!dcb_conflict_i) begin
				tag_we_o = 1'b1;
				tag_wr_o.valid = 1'b1;
				tag_wr_o.dirty = bus_req_i.we;
				next_state = REFILL_WAIT;
			end
		end
		REFILL_WAIT: next_state = REFILL_REQ;    // memory address takes the new tag
		REFILL_REQ: begin
			if (fml_ack_i)
				next_state = REFILL_STREAM;
		end
		REFILL_STREAM: begin
			wr_fml = 1'b1;
			wr_bus = bus_req_i.we && (beat == '0);   // bus bytes win on the critical word
			wb_ack_o = (beat == OFFSET_W'(1));
			bc_inc = 1'b1;
			if (beat == OFFSET_W'(LINE_WORDS - 1))
				next_state = IDLE;
		end
		TEST_INVALIDATE: begin
			if (tag_rd_i.valid && tag_rd_i.dirty)
				next_state = EVICT;
			else
				next_state = INVALIDATE;
		end
		INVALIDATE: begin
			tag_we_o = 1'b1;
			wb_ack_o = 1'b1;
			next_state = IDLE;
		end
		default: next_state = IDLE;
	endcase
end

// an ack only answers a live bus cycle
a_ack_in_cycle: assert property (
	@(posedge sys_clk) disable iff (sys_rst) wb_ack_o |-> (wb_cyc_i && wb_stb_i)
);

// memory writes only while the line being pushed out is dirty
a_evict_dirty: assert property (
	@(posedge sys_clk) disable iff (sys_rst) fml_o.we |-> (tag_rd_i.valid && tag_rd_i.dirty)
);

endmodule

//--- fmlbrg/fmlbrg_datamem.sv
`timescale 1ns/1ps

module fmlbrg_datamem #(
	parameter int depth = 8     // word address bits
) (
	input  logic             sys_clk,

	input  logic [depth-1:0] a_i,
	input  logic [1:0]       we_i,       // one enable per byte lane
	input  logic [15:0]      di_i,
	output logic [15:0]      do_o,

	input  logic [depth-1:0] a2_i,
	output logic [15:0]      do2_o
);

logic [1:0][7:0] mem [0:(1 << depth)-1];

// ******************************
// port A, write first per byte
// ******************************
always_ff @(posedge sys_clk) begin
	for (int b = 0; b < 2; b++) begin
		if (we_i[b]) begin
			mem[a_i][b] <= di_i[8*b +: 8];
			do_o[8*b +: 8] <= di_i[8*b +: 8];
		end else
			do_o[8*b +: 8] <= mem[a_i][b];
	end
end

// port B only reads
always_ff @(posedge sys_clk)
	do2_o <= mem[a2_i];

// once the enables are driven they must stay driven
a_we_known: assert property (
	@(posedge sys_clk) !$isunknown($past(we_i)) |-> !$isunknown(we_i)
);

endmodule

//--- fmlbrg/fmlbrg_dcb.sv
`timescale 1ns/1ps

module fmlbrg_dcb import fmlbrg_pkg::*; (
	input  logic                        sys_clk,
	input  logic                        sys_rst,

	input  logic                        dcb_stb_i,
	input  word_adr_u                   dcb_adr_i,
	input  tag_entry_t                  tag_rd_i,
	input  logic [INDEX_W-1:0]          line_idx_i,
	input  logic                        refill_busy_i,

	output logic [INDEX_W-1:0]          tag_idx_o,
	output logic [INDEX_W+OFFSET_W-1:0] data_adr_o,
	output logic                        dcb_conflict_o,
	output logic                        dcb_hit_o
);

logic             same_line;
logic             can_hit_r;     // strobe seen and line not under refill
logic [TAG_W-1:0] tag_r;

assign same_line = (dcb_adr_i.f.index == line_idx_i);
assign tag_idx_o = dcb_adr_i.f.index;
assign data_adr_o = dcb_adr_i.flat[INDEX_W+OFFSET_W-1:0];
assign dcb_conflict_o = dcb_stb_i && same_line;

always_ff @(posedge sys_clk) begin
	if (sys_rst)
		can_hit_r <= 1'b0;
	else
		can_hit_r <= dcb_stb_i && !(refill_busy_i && same_line);
end

always_ff @(posedge sys_clk)
	tag_r <= dcb_adr_i.f.tag;

assign dcb_hit_o = can_hit_r && tag_rd_i.valid && (tag_rd_i.tag == tag_r);

// a line under refill never reports a hit
a_no_hit_in_refill: assert property (
	@(posedge sys_clk) disable iff (sys_rst)
	dcb_hit_o |-> !(refill_busy_i && ($past(dcb_adr_i.f.index) == line_idx_i))
);

endmodule

//--- fmlbrg/fmlbrg_tagmem.sv
`timescale 1ns/1ps

module fmlbrg_tagmem #(
	parameter int depth = 5,    // address bits
	parameter int width = 16
) (
	input  logic             sys_clk,

	input  logic [depth-1:0] a_i,
	input  logic             we_i,
	input  logic [width-1:0] di_i,
	output logic [width-1:0] do_o,

	input  logic [depth-1:0] a2_i,
	output logic [width-1:0] do2_o
);

logic [width-1:0] mem [0:(1 << depth)-1];

// every line powers up invalid and clean
initial begin
	for (int i = 0; i < (1 << depth); i++)
		mem[i] = '0;
end

always @(posedge sys_clk) begin
	if (we_i) begin
		mem[a_i] <= di_i;
		do_o <= di_i;           // new entry visible right away
	end else
		do_o <= mem[a_i];
	do2_o <= mem[a2_i];          // lookup port
end

endmodule

//--- rtl/fmlbrg_top.sv
`timescale 1ns/1ps

module fmlbrg_top import fmlbrg_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  bus_req_t    bus_req_i,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	output logic [15:0] wb_dat_o,
	output logic        wb_ack_o,

	output fml_req_t    fml_o,
	input  logic        fml_ack_i,
	input  logic [15:0] fml_di_i,

	input  logic        dcb_stb_i,
	input  word_adr_u   dcb_adr_i,
	output logic [15:0] dcb_dat_o,
	output logic        dcb_hit_o
);

logic [INDEX_W-1:0]          tag_idx;
logic                        tag_we;
tag_entry_t                  tag_wr;
tag_entry_t                  tag_rd;
logic [INDEX_W-1:0]          dcb_tag_idx;
tag_entry_t                  dcb_tag_rd;
logic [INDEX_W+OFFSET_W-1:0] data_adr;
logic [1:0]                  data_we;
logic [15:0]                 data_wr;
logic [15:0]                 data_rd;
logic [INDEX_W+OFFSET_W-1:0] dcb_data_adr;
logic                        dcb_conflict;
logic                        refill_busy;
logic [INDEX_W-1:0]          line_idx;

fmlbrg_ctrl u_ctrl (
	.sys_clk, .sys_rst, .bus_req_i, .wb_cyc_i, .wb_stb_i, .wb_ack_o, .wb_dat_o,
	.fml_o, .fml_ack_i, .fml_di_i,
	.tag_idx_o(tag_idx), .tag_we_o(tag_we), .tag_wr_o(tag_wr), .tag_rd_i(tag_rd),
	.data_adr_o(data_adr), .data_we_o(data_we), .data_wr_o(data_wr), .data_rd_i(data_rd),
	.dcb_conflict_i(dcb_conflict), .refill_busy_o(refill_busy), .line_idx_o(line_idx)
);

fmlbrg_tagmem #(.depth(INDEX_W), .width($bits(tag_entry_t))) u_tagmem (
	.sys_clk, .a_i(tag_idx), .we_i(tag_we), .di_i(tag_wr), .do_o(tag_rd),
	.a2_i(dcb_tag_idx), .do2_o(dcb_tag_rd)
);

fmlbrg_datamem #(.depth(INDEX_W + OFFSET_W)) u_datamem (
	.sys_clk, .a_i(data_adr), .we_i(data_we), .di_i(data_wr), .do_o(data_rd),
	.a2_i(dcb_data_adr), .do2_o(dcb_dat_o)
);

fmlbrg_dcb u_dcb (
	.sys_clk, .sys_rst, .dcb_stb_i, .dcb_adr_i, .tag_rd_i(dcb_tag_rd),
	.line_idx_i(line_idx), .refill_busy_i(refill_busy),
	.tag_idx_o(dcb_tag_idx), .data_adr_o(dcb_data_adr),
	.dcb_conflict_o(dcb_conflict), .dcb_hit_o
);

endmodule

//--- verilog.f
common/fmlbrg_pkg.sv
fmlbrg/fmlbrg_tagmem.sv
fmlbrg/fmlbrg_datamem.sv
fmlbrg/fmlbrg_ctrl.sv
fmlbrg/fmlbrg_dcb.sv
rtl/fmlbrg_top.sv
bench/fml_mem_model.sv
bench/tb_fmlbrg.sv
